// File: hw/branch_history_table.sv
`timescale 1ns/10ps
`default_nettype none

module branch_history_table (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [core_pkg::im_addr_nbit-1:0] fetch_pc,
    input  core_pkg::bht_train_t              train,
    output logic [core_pkg::im_addr_nbit-1:0] pred_pc
);
    import core_pkg::*;

    logic [1:0]              cnt_q [bht_entries]; // two-bit saturating counters
    logic [im_addr_nbit-1:0] tgt_q [bht_entries];
    logic [bht_idx_nbit-1:0] rd_idx;
    logic [bht_idx_nbit-1:0] wr_idx;

    assign rd_idx = fetch_pc[bht_idx_nbit+1:2]; // word aligned
    assign wr_idx = train.pc[bht_idx_nbit+1:2];

    assign pred_pc = cnt_q[rd_idx][1] ? tgt_q[rd_idx] : fetch_pc + im_addr_nbit'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < bht_entries; i++) begin
                cnt_q[i] <= 2'b01; // weakly not taken
                tgt_q[i] <= '0;
            end
        end else begin
            case (train.op)
                bht_op_set: begin
                    cnt_q[wr_idx] <= 2'b11;
                    tgt_q[wr_idx] <= train.target;
                end
                bht_op_inc: begin
                    if (cnt_q[wr_idx] != 2'b11)
                        cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'b01;
                    tgt_q[wr_idx] <= train.target;
                end
                bht_op_dec: begin
                    if (cnt_q[wr_idx] != 2'b00)
                        cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'b01;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int im_addr_nbit = 32;
    localparam int bht_idx_nbit = 4;
    localparam int bht_entries  = 1 << bht_idx_nbit;

    typedef logic [4:0] reg_idx_t; // r0 is hardwired zero

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mux and operation encodings

    typedef enum logic [1:0] {
        rf_dataw_alu,
        rf_dataw_dm,  // load data, the only late source
        rf_dataw_pc4,
        rf_dataw_rc0
    } mux_rf_dataw_e;

    typedef enum logic [1:0] {
        fwd_rf_norm,
        fwd_rf_tmp,   // from execute
        fwd_rf_dat    // from memory
    } mux_fwd_rf_e;

    typedef enum logic [1:0] {
        fwd_rc0_norm,
        fwd_rc0_ex,
        fwd_rc0_ma
    } mux_fwd_rc0_e;

    typedef enum logic [1:0] {
        bht_op_nop,
        bht_op_set,
        bht_op_inc,
        bht_op_dec
    } bht_op_e;

    typedef logic [1:0] rc0_op_t; // bit 1 is eret or trap

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage information

    typedef struct packed {
        logic [im_addr_nbit-1:0] pc;
        logic                    ra;    // source a is read
        logic                    rb;    // source b is read
        reg_idx_t                req_a;
        reg_idx_t                req_b;
    } id_info_t;

    typedef struct packed {
        logic [im_addr_nbit-1:0] pc;
        logic [im_addr_nbit-1:0] pc_4;
        logic                    rf_we;
        reg_idx_t                req_w;
        mux_rf_dataw_e           wb_src;
        rc0_op_t                 rc0_op;
        logic                    rc0_ie_we;
        logic                    rc0_epc_we;
        logic                    is_jump;
        logic                    is_branch;
        logic                    branched;
        logic [im_addr_nbit-1:0] wtg_pc_new; // resolved jump or branch target
        logic                    halt;
    } ex_info_t;

    typedef struct packed {
        logic     rf_we;
        reg_idx_t req_w;
        logic     rc0_ie_we;
        logic     rc0_epc_we;
    } ma_info_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller outputs

    typedef struct packed {
        logic                    pc_en;
        logic                    pc_ld_wtg;
        logic [im_addr_nbit-1:0] redirect_pc;
        logic                    ifid_en;
        logic                    ifid_nop;
        logic                    idex_en;
        logic                    idex_nop;
    } pipe_ctrl_t;

    typedef struct packed {
        mux_fwd_rf_e  rf_a;
        mux_fwd_rf_e  rf_b;
        mux_fwd_rc0_e rc0_ie;
        mux_fwd_rc0_e rc0_epc;
    } fwd_sel_t;

    typedef struct packed {
        bht_op_e                 op;
        logic [im_addr_nbit-1:0] pc;
        logic [im_addr_nbit-1:0] target;
    } bht_train_t;

endpackage

`default_nettype wire

// File: hw/fetch_pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_unit (
    input  logic                              clk,
    input  logic                              arst_n,
    input  core_pkg::pipe_ctrl_t              ctrl,
    input  logic [core_pkg::im_addr_nbit-1:0] pred_pc,
    output logic [core_pkg::im_addr_nbit-1:0] fetch_pc
);

    // redirect from execute, then stall hold, then prediction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= '0;
        end else if (ctrl.pc_ld_wtg) begin
            fetch_pc <= ctrl.redirect_pc;
        end else if (ctrl.pc_en) begin
            fetch_pc <= pred_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/perf_counter_apb.sv
`timescale 1ns/10ps
`default_nettype none

module perf_counter_apb (
    input  logic                               clk,
    input  logic                               arst_n,
    input  perf_pkg::pipe_evt_t                evt,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [perf_pkg::apb_addr_nbit-1:0] paddr,
    input  logic [perf_pkg::apb_data_nbit-1:0] pwdata,
    output logic [perf_pkg::apb_data_nbit-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr
);
    import perf_pkg::*;

    logic [cnt_nbit-1:0] cnt_q [4];
    logic [3:0]          evt_vec;
    logic [1:0]          sel;
    logic                addr_ok;
    logic                wr_clr;

    assign evt_vec = {evt.flush, evt.stall, evt.miss, evt.hit}; // counter index order

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode

    always_comb begin
        addr_ok = 1'b1;
        case (paddr)
            addr_hit:   sel = 2'd0;
            addr_miss:  sel = 2'd1;
            addr_stall: sel = 2'd2;
            addr_flush: sel = 2'd3;
            default: begin
                sel     = 2'd0;
                addr_ok = 1'b0;
            end
        endcase
    end

    assign wr_clr  = psel && penable && pwrite && addr_ok; // write data is don't care
    assign pready  = 1'b1;
    assign pslverr = psel && penable && !addr_ok;
    assign prdata  = (psel && addr_ok) ? apb_data_nbit'(cnt_q[sel]) : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // saturating counters, clear beats a same-cycle event

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++)
                cnt_q[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr_clr && (sel == 2'(i)))
                    cnt_q[i] <= '0;
                else if (evt_vec[i] && (cnt_q[i] != '1))
                    cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/perf_pkg.sv
`default_nettype none

package perf_pkg;

    localparam int cnt_nbit      = 16;
    localparam int apb_addr_nbit = 4;
    localparam int apb_data_nbit = 32;

    // counter register map
    localparam logic [apb_addr_nbit-1:0] addr_hit   = 4'h0;
    localparam logic [apb_addr_nbit-1:0] addr_miss  = 4'h4;
    localparam logic [apb_addr_nbit-1:0] addr_stall = 4'h8;
    localparam logic [apb_addr_nbit-1:0] addr_flush = 4'hC;

    typedef struct packed {
        logic hit;   // prediction confirmed in execute
        logic miss;
        logic stall;
        logic flush;
    } pipe_evt_t;

endpackage

`default_nettype wire

// File: hw/pipe_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  core_pkg::id_info_t                 id,
    input  core_pkg::ex_info_t                 ex,
    input  core_pkg::ma_info_t                 ma,
    output core_pkg::pipe_ctrl_t               ctrl,
    output core_pkg::fwd_sel_t                 fwd,
    output logic [core_pkg::im_addr_nbit-1:0]  fetch_pc,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [perf_pkg::apb_addr_nbit-1:0] paddr,
    input  logic [perf_pkg::apb_data_nbit-1:0] pwdata,
    output logic [perf_pkg::apb_data_nbit-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr
);
    import core_pkg::*;
    import perf_pkg::*;

    bht_train_t              train;
    pipe_evt_t               evt;
    logic [im_addr_nbit-1:0] pred_pc;

    pipe_hazard_ctrl pipe_hazard_ctrl_inst (
        .id    (id),
        .ex    (ex),
        .ma    (ma),
        .ctrl  (ctrl),
        .fwd   (fwd),
        .train (train),
        .evt   (evt)
    );

    branch_history_table branch_history_table_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .fetch_pc (fetch_pc),
        .train    (train),
        .pred_pc  (pred_pc)
    );

    fetch_pc_unit fetch_pc_unit_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .pred_pc  (pred_pc),
        .fetch_pc (fetch_pc)
    );

    perf_counter_apb perf_counter_apb_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .evt     (evt),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

`default_nettype wire

// File: hw/pipe_hazard_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_hazard_ctrl (
    input  core_pkg::id_info_t   id,
    input  core_pkg::ex_info_t   ex,
    input  core_pkg::ma_info_t   ma,
    output core_pkg::pipe_ctrl_t ctrl,
    output core_pkg::fwd_sel_t   fwd,
    output core_pkg::bht_train_t train,
    output perf_pkg::pipe_evt_t  evt
);
    import core_pkg::*;

    logic                    need_a, need_b;
    logic                    wr_ex, wr_ma;
    logic                    a_ex, a_ma, b_ex, b_ma;
    logic                    ex_load;
    logic                    ex_jorb;
    logic                    ex_bubble;
    logic [im_addr_nbit-1:0] pc_correct;
    logic                    is_stall;
    logic                    is_flush;
    logic                    do_train;

    // execute beats memory, a load in execute cannot be forwarded yet
    function automatic mux_fwd_rf_e rf_sel(input logic hit_ex, input logic hit_ma,
                                           input logic load);
        mux_fwd_rf_e sel;
        sel = fwd_rf_norm;
        if (hit_ex) begin
            if (!load)
                sel = fwd_rf_tmp;
        end else if (hit_ma) begin
            sel = fwd_rf_dat;
        end
        return sel;
    endfunction

    function automatic mux_fwd_rc0_e rc0_sel(input logic we_ex, input logic we_ma);
        mux_fwd_rc0_e sel;
        sel = fwd_rc0_norm;
        if (we_ex)
            sel = fwd_rc0_ex;
        else if (we_ma)
            sel = fwd_rc0_ma;
        return sel;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register hazards

    assign need_a  = id.ra && (id.req_a != '0);
    assign need_b  = id.rb && (id.req_b != '0);
    assign wr_ex   = ex.rf_we && (ex.req_w != '0);
    assign wr_ma   = ma.rf_we && (ma.req_w != '0);
    assign a_ex    = need_a && wr_ex && (id.req_a == ex.req_w);
    assign a_ma    = need_a && wr_ma && (id.req_a == ma.req_w);
    assign b_ex    = need_b && wr_ex && (id.req_b == ex.req_w);
    assign b_ma    = need_b && wr_ma && (id.req_b == ma.req_w);
    assign ex_load = (ex.wb_src == rf_dataw_dm);

    assign is_stall = ((a_ex || b_ex) && ex_load) || ex.halt; // load-use or halt

    assign fwd.rf_a    = rf_sel(a_ex, a_ma, ex_load);
    assign fwd.rf_b    = rf_sel(b_ex, b_ma, ex_load);
    assign fwd.rc0_ie  = rc0_sel(ex.rc0_ie_we, ma.rc0_ie_we);
    assign fwd.rc0_epc = rc0_sel(ex.rc0_epc_we, ma.rc0_epc_we);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flush and redirect

    assign ex_jorb    = ex.is_jump || ex.is_branch;
    assign ex_bubble  = (ex.pc == ex.pc_4);
    assign pc_correct = ex_jorb ? ex.wtg_pc_new : ex.pc_4;
    assign is_flush   = ex.rc0_op[1] || (!ex_bubble && (id.pc != pc_correct));

    always_comb begin
        ctrl.pc_en       = !is_stall;
        ctrl.ifid_en     = !is_stall;
        ctrl.idex_en     = 1'b1;
        ctrl.idex_nop    = is_stall || is_flush;
        ctrl.pc_ld_wtg   = is_flush; // wins over the stall in the pc unit
        ctrl.ifid_nop    = is_flush;
        ctrl.redirect_pc = pc_correct;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // predictor training and events

    assign do_train = ex_jorb && !ex.rc0_op[1];

    always_comb begin
        train.pc     = ex.pc;
        train.target = ex.wtg_pc_new;
        if (!do_train)
            train.op = bht_op_nop;
        else if (ex.is_jump)
            train.op = bht_op_set;
        else
            train.op = ex.branched ? bht_op_inc : bht_op_dec;
    end

    assign evt.hit   = do_train && !is_flush;
    assign evt.miss  = do_train && is_flush;
    assign evt.stall = is_stall;
    assign evt.flush = is_flush;

endmodule

`default_nettype wire

// File: pipe_ctrl_top.f
hw/core_pkg.sv
hw/perf_pkg.sv
hw/pipe_hazard_ctrl.sv
hw/branch_history_table.sv
hw/fetch_pc_unit.sv
hw/perf_counter_apb.sv
hw/pipe_ctrl_top.sv
test/pipe_ctrl_tb.sv

// File: test/pipe_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl_tb;
    import core_pkg::*;
    import perf_pkg::*;

    localparam int n_rand       = 400;
    localparam int total_cycles = 16 + n_rand + 120;
    localparam logic [4:0] k_jump   = 5'b00001; // flow kind bits
    localparam logic [4:0] k_branch = 5'b00010;
    localparam logic [4:0] k_taken  = 5'b00100;
    localparam logic [4:0] k_trap   = 5'b01000;
    localparam logic [4:0] k_halt   = 5'b10000;

    logic        clk = 1'b0;
    logic        arst_n;
    id_info_t    id;
    ex_info_t    ex;
    ma_info_t    ma;
    pipe_ctrl_t  ctrl;
    fwd_sel_t    fwd;
    logic [31:0] fetch_pc;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [3:0]  paddr;
    logic [31:0] pwdata, prdata;

    // reference models
    logic [31:0] pc_m;
    logic [1:0]  bht_cnt [16];
    logic [31:0] bht_tgt [16];
    logic [15:0] cnt_m [4];
    pipe_ctrl_t  exp_c, got_c;
    fwd_sel_t    exp_f;
    pipe_evt_t   exp_v;
    bht_train_t  exp_t;
    logic [31:0] pred;
    logic [3:0]  evs;
    logic        apb_acc, apb_ok;
    logic [15:0] lfsr;
    int          n_err = 0;
    int          n_chk = 0;
    int          n_test = 0;
    int          n_fail = 0;
    int          err_mark = 0;

    pipe_ctrl_top pipe_ctrl_top_inst (
        .clk (clk), .arst_n (arst_n), .id (id), .ex (ex), .ma (ma),
        .ctrl (ctrl), .fwd (fwd), .fetch_pc (fetch_pc),
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr ^= 16'hB400;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // expected controller response from the hazard and flush rules
    function automatic void ref_ctrl(input id_info_t i, input ex_info_t e, input ma_info_t m,
                                     output pipe_ctrl_t c, output fwd_sel_t f,
                                     output pipe_evt_t v, output bht_train_t t);
        logic [4:0]  src [2];
        logic        rd [2];
        mux_fwd_rf_e sel [2];
        logic        load_use, stall, flush, jb;
        logic [31:0] good;
        src[0]   = i.req_a;
        src[1]   = i.req_b;
        rd[0]    = i.ra;
        rd[1]    = i.rb;
        load_use = 1'b0;
        for (int k = 0; k < 2; k++) begin
            sel[k] = fwd_rf_norm;
            if (rd[k] && src[k] != 5'd0) begin
                if (e.rf_we && e.req_w == src[k]) begin
                    if (e.wb_src == rf_dataw_dm)
                        load_use = 1'b1; // value not ready until memory
                    else
                        sel[k] = fwd_rf_tmp;
                end else if (m.rf_we && m.req_w == src[k]) begin
                    sel[k] = fwd_rf_dat;
                end
            end
        end
        f.rf_a    = sel[0];
        f.rf_b    = sel[1];
        f.rc0_ie  = e.rc0_ie_we ? fwd_rc0_ex : (m.rc0_ie_we ? fwd_rc0_ma : fwd_rc0_norm);
        f.rc0_epc = e.rc0_epc_we ? fwd_rc0_ex : (m.rc0_epc_we ? fwd_rc0_ma : fwd_rc0_norm);
        stall = load_use || e.halt;
        jb    = e.is_jump || e.is_branch;
        good  = jb ? e.wtg_pc_new : e.pc_4;
        flush = e.rc0_op[1] || ((e.pc != e.pc_4) && (i.pc != good));
        c             = '0;
        c.pc_en       = !stall;
        c.ifid_en     = !stall;
        c.idex_en     = 1'b1;
        c.idex_nop    = stall || flush;
        c.pc_ld_wtg   = flush;
        c.ifid_nop    = flush;
        c.redirect_pc = good;
        t.pc     = e.pc;
        t.target = e.wtg_pc_new;
        if (!jb || e.rc0_op[1])
            t.op = bht_op_nop;
        else if (e.is_jump)
            t.op = bht_op_set;
        else
            t.op = e.branched ? bht_op_inc : bht_op_dec;
        v.hit   = (t.op != bht_op_nop) && !flush;
        v.miss  = (t.op != bht_op_nop) && flush;
        v.stall = stall;
        v.flush = flush;
    endfunction

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("Mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = n_err - err_mark;
        n_test++;
        if (errs != 0)
            n_fail++;
        $display("test %0d %s %s, %0d mismatches", n_test, name,
                 (errs == 0) ? "ok" : "bad", errs);
        err_mark = n_err;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare before each rising edge and step the models

    always @(negedge clk) begin
        if (arst_n) begin
            ref_ctrl(id, ex, ma, exp_c, exp_f, exp_v, exp_t);
            got_c = ctrl;
            if (!exp_c.pc_ld_wtg)
                got_c.redirect_pc = exp_c.redirect_pc; // only meaningful on a flush
            check_val(got_c, exp_c, "ctrl");
            check_val(fwd, exp_f, "fwd");
            check_val(fetch_pc, pc_m, "fetch_pc");
            apb_acc = psel && penable;
            apb_ok  = (paddr[1:0] == 2'b00);
            check_val(pslverr, apb_acc && !apb_ok, "pslverr");
            if (apb_acc)
                check_val(pready, 1'b1, "pready");
            if (apb_acc && !pwrite && apb_ok)
                check_val(prdata, cnt_m[paddr[3:2]], "prdata");
            if (!psel)
                check_val(prdata, 32'h0, "prdata idle");
            pred = bht_cnt[pc_m[5:2]][1] ? bht_tgt[pc_m[5:2]] : pc_m + 32'd4;
            pc_m = exp_c.pc_ld_wtg ? exp_c.redirect_pc : (exp_c.pc_en ? pred : pc_m);
            case (exp_t.op)
                bht_op_set: begin
                    bht_cnt[exp_t.pc[5:2]] = 2'b11;
                    bht_tgt[exp_t.pc[5:2]] = exp_t.target;
                end
                bht_op_inc: begin
                    if (bht_cnt[exp_t.pc[5:2]] != 2'b11)
                        bht_cnt[exp_t.pc[5:2]]++;
                    bht_tgt[exp_t.pc[5:2]] = exp_t.target;
                end
                bht_op_dec: begin
                    if (bht_cnt[exp_t.pc[5:2]] != 2'b00)
                        bht_cnt[exp_t.pc[5:2]]--;
                end
                default: ;
            endcase
            evs = {exp_v.flush, exp_v.stall, exp_v.miss, exp_v.hit};
            for (int k = 0; k < 4; k++) begin
                if (apb_acc && pwrite && apb_ok && paddr[3:2] == 2'(k))
                    cnt_m[k] = '0;
                else if (evs[k] && cnt_m[k] != 16'hFFFF)
                    cnt_m[k]++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus

    task automatic drive_cycle(input id_info_t i, input ex_info_t e, input ma_info_t m);
        @(posedge clk);
        #1;
        id = i;
        ex = e;
        ma = m;
    endtask

    // kind is {halt, trap, taken, branch, jump}
    task automatic flow(input logic [31:0] id_pc, input logic [31:0] ex_pc,
                        input logic [31:0] ex_pc4, input logic [31:0] tgt,
                        input logic [4:0] kind);
        id_info_t i;
        ex_info_t e;
        i            = '0;
        e            = '0;
        i.pc         = id_pc;
        e.pc         = ex_pc;
        e.pc_4       = ex_pc4;
        e.wtg_pc_new = tgt;
        {e.halt, e.rc0_op[1], e.branched, e.is_branch, e.is_jump} = kind;
        drive_cycle(i, e, '0);
    endtask

    task automatic drive_random();
        id_info_t    i;
        ex_info_t    e;
        ma_info_t    m;
        logic [1:0]  w;
        logic [31:0] good;
        i            = '0;
        e            = '0;
        m            = '0;
        e.pc         = rnd(4) << 2;
        e.pc_4       = (rnd(2) == 0) ? e.pc : e.pc + 32'd4; // some bubbles
        e.is_jump    = (rnd(2) == 0);
        e.is_branch  = !e.is_jump && rnd(1);
        e.branched   = 1'(rnd(1));
        e.wtg_pc_new = rnd(4) << 2;
        e.rc0_op[1]  = (rnd(3) == 0);
        e.rc0_op[0]  = 1'(rnd(1));
        e.halt       = (rnd(4) == 0);
        e.rf_we      = 1'(rnd(1));
        e.req_w      = 5'(rnd(2));
        w            = 2'(rnd(2));
        e.wb_src     = mux_rf_dataw_e'(w);
        e.rc0_ie_we  = 1'(rnd(1));
        e.rc0_epc_we = 1'(rnd(1));
        m.rf_we      = 1'(rnd(1));
        m.req_w      = 5'(rnd(2));
        m.rc0_ie_we  = 1'(rnd(1));
        m.rc0_epc_we = 1'(rnd(1));
        i.ra         = 1'(rnd(1));
        i.rb         = 1'(rnd(1));
        i.req_a      = 5'(rnd(2));
        i.req_b      = 5'(rnd(2));
        good         = (e.is_jump || e.is_branch) ? e.wtg_pc_new : e.pc_4;
        i.pc         = rnd(1) ? good : rnd(4) << 2;
        drive_cycle(i, e, m);
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = rnd(32); // ignored by the slave
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence

    initial begin
        logic [31:0] d;
        logic        err;
        arst_n  = 1'b0;
        id      = '0;
        ex      = '0;
        ma      = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 16'd55514;
        pc_m    = '0;
        for (int k = 0; k < 16; k++) begin
            bht_cnt[k] = 2'b01;
            bht_tgt[k] = '0;
        end
        for (int k = 0; k < 4; k++)
            cnt_m[k] = '0;
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;

        repeat (n_rand) drive_random();
        flow(0, 0, 0, 0, 5'b0);
        end_test("hazard");

        flow(32'h20, 32'h10, 32'h14, 32'h20, k_jump);           // predicted right
        flow(32'h14, 32'h10, 32'h14, 32'h30, k_jump);           // jump missed
        flow(32'h18, 32'h10, 32'h14, 32'h14, k_branch);         // not taken but fetched past it
        flow(32'h14, 32'h10, 32'h14, 32'h00, k_trap);
        flow(32'h99c, 32'h10, 32'h10, 32'h00, 5'b0);            // bubble never flushes
        flow(0, 0, 0, 0, 5'b0);
        end_test("flush");

        repeat (2) flow(32'h100, 32'h40, 32'h44, 32'h100, k_branch | k_taken);
        flow(0, 32'h3C, 32'h40, 0, 5'b0);                       // redirect to 0x40
        repeat (2) flow(0, 0, 0, 0, 5'b0);
        check_val(fetch_pc, 32'h100, "predicted target");
        repeat (3) flow(32'h44, 32'h40, 32'h44, 32'h44, k_branch);
        flow(0, 32'h3C, 32'h40, 0, 5'b0);
        repeat (2) flow(0, 0, 0, 0, 5'b0);
        check_val(fetch_pc, 32'h44, "fall through after decrements");
        end_test("predictor");

        repeat (2) flow(0, 0, 0, 0, k_halt);                    // hold
        flow(32'h80, 32'h20, 32'h24, 0, k_halt | k_trap);       // redirect beats stall
        flow(0, 0, 0, 0, 5'b0);
        check_val(fetch_pc, 32'h24, "redirect under stall");
        repeat (2) flow(0, 0, 0, 0, 5'b0);
        end_test("pc order");

        for (int k = 0; k < 4; k++)
            apb_xfer(1'b0, 4'(k * 4), d, err);
        apb_xfer(1'b1, 4'h4, d, err);
        for (int k = 0; k < 4; k++)
            apb_xfer(1'b0, 4'(k * 4), d, err);
        apb_xfer(1'b0, 4'h4, d, err);
        check_val(d, 32'h0, "miss count after clear");
        apb_xfer(1'b0, 4'h2, d, err);
        check_val(err, 1'b1, "pslverr on unknown address");
        end_test("apb");

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 n_test, n_fail, n_chk, n_err);
        if (n_err == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial begin
        #(total_cycles * 10 * 2);
        $display("timeout: run did not finish within %0d ns", total_cycles * 10 * 2);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
